// File: design/execUnit.sv
`default_nettype none
`timescale 1ns/1ps

module execUnit (
    input  logic             clk,
    input  logic             executeEn,
    input  tenyrPkg::opcodeT opcode,
    input  tenyrPkg::wordT   left,
    input  tenyrPkg::wordT   right,
    input  tenyrPkg::wordT   addend,
    output tenyrPkg::wordT   rhs
);

    import tenyrPkg::*;

    wordT opResult;
    logic signedLt;
    logic signedGt;
    logic isEqual;

    assign signedLt = $signed(left) < $signed(right);
    assign signedGt = $signed(left) > $signed(right);
    assign isEqual  = (left == right);

    always_comb begin
        case (opcode)
            opOr: begin
                opResult = left | right;
            end
            opAnd: begin
                opResult = left & right;
            end
            opAdd: begin
                opResult = left + right;
            end
            opMul: begin
                opResult = left * right;  // Low word of product
            end
            opShl: begin
                opResult = left << right;  // Full shift count, large counts give zero
            end
            opLt: begin
                opResult = {wordWidth{signedLt}};
            end
            opEq: begin
                opResult = {wordWidth{isEqual}};
            end
            opGt: begin
                opResult = {wordWidth{signedGt}};
            end
            opAndNot: begin
                opResult = left & ~right;
            end
            opXor: begin
                opResult = left ^ right;
            end
            opSub: begin
                opResult = left - right;
            end
            opXnor: begin
                opResult = left ^ ~right;
            end
            opShr: begin
                opResult = left >> right;  // Logical
            end
            opNe: begin
                opResult = {wordWidth{!isEqual}};
            end
            default: begin
                opResult = '0;  // Reserved codes
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (executeEn) begin
            rhs <= opResult + addend;
        end
    end

endmodule

`default_nettype wire

// File: design/instrDecoder.sv
`default_nettype none
`timescale 1ns/1ps

module instrDecoder (
    input  tenyrPkg::wordT     instr,
    output tenyrPkg::regIndexT indexZ,
    output tenyrPkg::regIndexT indexX,
    output tenyrPkg::regIndexT indexY,
    output tenyrPkg::opcodeT   opcode,
    output tenyrPkg::wordT     immediate,
    output logic               operandSwap,
    output logic               storing,
    output logic               derefRhs,
    output logic               branch,
    output logic               illegal
);

    import tenyrPkg::*;

    logic [immWidth-1:0] rawImm;

    assign operandSwap = instr[typeBit];  // Immediate moves to the right operand
    assign storing     = instr[storeBit];
    assign derefRhs    = instr[derefBit];

    assign indexZ = instr[zLsb +: 4];
    assign indexX = instr[xLsb +: 4];
    assign indexY = instr[yLsb +: 4];
    assign opcode = instr[opcodeLsb +: 4];

    assign rawImm    = instr[immWidth-1:0];
    assign immediate = {{(wordWidth - immWidth){rawImm[immWidth-1]}}, rawImm}; // Sign extend

    // Writing Z=PC without a store redirects the fetch
    assign branch  = (indexZ == pcIndex) && !storing;
    assign illegal = &instr;  // All-ones word halts

endmodule

`default_nettype wire

// File: design/phaseSequencer.sv
`default_nettype none
`timescale 1ns/1ps

module phaseSequencer (
    input  logic            clk,
    input  logic            reset_n,
    input  logic            enable,
    input  logic            haltReq,
    input  logic            illegal,
    output tenyrPkg::phaseT phase,
    output logic            executeEn,
    output logic            commitEn,
    output logic            writeEn,
    output logic            halted
);

    import tenyrPkg::*;

    phaseT mask;    // Trails phase by one rotation after reset
    phaseT active;
    logic  running;
    logic  atBoundary;

    assign running    = enable && !halted;
    assign active     = phase & mask;
    assign atBoundary = (phase == phaseWriteback);

    assign executeEn = running && (active == phaseExecute);
    assign commitEn  = running && (active == phaseCommit);
    assign writeEn   = running && (active == phaseWriteback);

    always_ff @(posedge clk) begin
        if (!reset_n) begin
            phase  <= phaseFetch;
            mask   <= '0;
            halted <= 1'b0;
        end else if (running) begin
            phase <= {phase[2:0], phase[3]};
            // A new instruction only starts if no halt is requested
            mask  <= {mask[2:0], atBoundary && !haltReq};
            if ((executeEn && illegal) || (atBoundary && haltReq)) begin
                halted <= 1'b1;  // Sticky until reset
            end
        end
    end

    assert property (@(posedge clk) disable iff (!reset_n) $onehot(phase));

    assert property (@(posedge clk) disable iff (!reset_n)
        $onehot0({executeEn, commitEn, writeEn}));

endmodule

`default_nettype wire

// File: design/programCounter.sv
`default_nettype none
`timescale 1ns/1ps

module programCounter #(
    parameter tenyrPkg::wordT resetVector = tenyrPkg::defaultResetVector
) (
    input  logic           clk,
    input  logic           reset_n,
    input  logic           commitEn,
    input  logic           branch,
    input  tenyrPkg::wordT target,
    output tenyrPkg::wordT instrAddr,
    output tenyrPkg::wordT nextPc
);

    import tenyrPkg::*;

    wordT loadAddr;

    assign loadAddr = branch ? target : nextPc;  // Taken branch or fall through

    always_ff @(posedge clk) begin
        if (!reset_n) begin
            instrAddr <= resetVector;
            nextPc    <= resetVector + 1'b1;
        end else if (commitEn) begin
            instrAddr <= loadAddr;
            nextPc    <= loadAddr + 1'b1;
        end
    end

    // Register 15 must always see the address after the current fetch
    assert property (@(posedge clk) disable iff (!reset_n)
        !commitEn |-> (nextPc == instrAddr + 1'b1));

endmodule

`default_nettype wire

// File: design/regFile.sv
`default_nettype none
`timescale 1ns/1ps

module regFile (
    input  logic               clk,
    input  logic               reset_n,
    input  logic               writeEn,
    input  tenyrPkg::regIndexT indexZ,
    input  tenyrPkg::regIndexT indexX,
    input  tenyrPkg::regIndexT indexY,
    input  tenyrPkg::wordT     writeData,
    input  tenyrPkg::wordT     nextPc,
    output tenyrPkg::wordT     valueZ,
    output tenyrPkg::wordT     valueX,
    output tenyrPkg::wordT     valueY
);

    import tenyrPkg::*;

    wordT regs [1:14];  // Only the writable registers are stored

    logic zIsZero;
    logic zIsPc;
    logic commitWrite;

    function automatic wordT readPort(input regIndexT index, input wordT pcValue);
        wordT value;
        if (index == zeroIndex) begin
            value = '0;
        end else if (index == pcIndex) begin
            value = pcValue;
        end else begin
            value = regs[index];
        end
        return value;
    endfunction

    assign valueZ = readPort(indexZ, nextPc);
    assign valueX = readPort(indexX, nextPc);
    assign valueY = readPort(indexY, nextPc);

    assign zIsZero     = (indexZ == zeroIndex);
    assign zIsPc       = (indexZ == pcIndex);
    assign commitWrite = reset_n && writeEn && !zIsZero && !zIsPc;

    always_ff @(posedge clk) begin
        if (commitWrite) begin
            regs[indexZ] <= writeData;
        end
    end

    // A write aimed at r0 leaves the stored registers untouched
    assert property (@(posedge clk) disable iff (!reset_n)
        (writeEn && zIsZero) |=>
            (!$stable(indexX) || indexX == pcIndex || $stable(valueX)));

endmodule

`default_nettype wire

// File: design/tenyrCore.sv
`default_nettype none
`timescale 1ns/1ps

module tenyrCore #(
    parameter tenyrPkg::wordT resetVector = tenyrPkg::defaultResetVector
) (
    input  logic           clk,
    input  logic           reset_n,
    input  logic           enable,
    output tenyrPkg::wordT instrAddr,
    input  tenyrPkg::wordT instrData,
    output tenyrPkg::wordT dataAddr,
    output logic           dataWe,
    output tenyrPkg::wordT dataOut,
    input  tenyrPkg::wordT dataIn,
    input  logic           haltReq,
    output logic           halted
);

    import tenyrPkg::*;

    phaseT    phase;
    logic     executeEn;
    logic     commitEn;
    logic     writeEn;
    wordT     instr;
    regIndexT indexZ;
    regIndexT indexX;
    regIndexT indexY;
    opcodeT   opcode;
    wordT     immediate;
    logic     operandSwap;
    logic     storing;
    logic     derefRhs;
    logic     branch;
    logic     illegal;
    wordT     valueZ;
    wordT     valueX;
    wordT     valueY;
    wordT     right;
    wordT     addend;
    wordT     rhs;
    wordT     rhsValue;
    wordT     nextPc;

    phaseSequencer u_phaseSequencer (
        .clk       (clk),
        .reset_n   (reset_n),
        .enable    (enable),
        .haltReq   (haltReq),
        .illegal   (illegal),
        .phase     (phase),
        .executeEn (executeEn),
        .commitEn  (commitEn),
        .writeEn   (writeEn),
        .halted    (halted)
    );

    programCounter #(
        .resetVector (resetVector)
    ) u_programCounter (
        .clk       (clk),
        .reset_n   (reset_n),
        .commitEn  (commitEn),
        .branch    (branch),
        .target    (rhsValue),
        .instrAddr (instrAddr),
        .nextPc    (nextPc)
    );

    // Instruction latch, memory answers within the fetch cycle
    always_ff @(posedge clk) begin
        if (enable && phase == phaseFetch) begin
            instr <= instrData;
        end
    end

    instrDecoder u_instrDecoder (
        .instr       (instr),
        .indexZ      (indexZ),
        .indexX      (indexX),
        .indexY      (indexY),
        .opcode      (opcode),
        .immediate   (immediate),
        .operandSwap (operandSwap),
        .storing     (storing),
        .derefRhs    (derefRhs),
        .branch      (branch),
        .illegal     (illegal)
    );

    regFile u_regFile (
        .clk       (clk),
        .reset_n   (reset_n),
        .writeEn   (writeEn && !storing),  // Stores leave Z untouched
        .indexZ    (indexZ),
        .indexX    (indexX),
        .indexY    (indexY),
        .writeData (rhsValue),
        .nextPc    (nextPc),
        .valueZ    (valueZ),
        .valueX    (valueX),
        .valueY    (valueY)
    );

    assign right  = operandSwap ? immediate : valueY;  // Z <- X op I + Y form
    assign addend = operandSwap ? valueY : immediate;

    execUnit u_execUnit (
        .clk       (clk),
        .executeEn (executeEn),
        .opcode    (opcode),
        .left      (valueX),
        .right     (right),
        .addend    (addend),
        .rhs       (rhs)
    );

    assign rhsValue = derefRhs ? dataIn : rhs;
    assign dataAddr = derefRhs ? rhs : valueZ;
    assign dataOut  = derefRhs ? valueZ : rhs;
    assign dataWe   = storing && commitEn;

    // A store may only leave the core in the commit phase of a live core
    assert property (@(posedge clk) disable iff (!reset_n)
        dataWe |-> (phase == phaseCommit) && !halted);

endmodule

`default_nettype wire

// File: design/tenyrPkg.sv
`default_nettype none

package tenyrPkg;

    localparam int wordWidth = 32;
    localparam int immWidth  = 12;

    typedef logic [wordWidth-1:0] wordT;
    typedef logic [3:0]           regIndexT;
    typedef logic [3:0]           opcodeT;
    typedef logic [3:0]           phaseT;

    // Bit positions inside an instruction word
    localparam int typeBit   = 30;
    localparam int storeBit  = 29;
    localparam int derefBit  = 28;
    localparam int zLsb      = 24;
    localparam int xLsb      = 20;
    localparam int yLsb      = 16;
    localparam int opcodeLsb = 12;

    // ALU operations, codes 4 and 15 reserved
    localparam opcodeT opOr     = 4'h0;
    localparam opcodeT opAnd    = 4'h1;
    localparam opcodeT opAdd    = 4'h2;
    localparam opcodeT opMul    = 4'h3;
    localparam opcodeT opShl    = 4'h5;
    localparam opcodeT opLt     = 4'h6;
    localparam opcodeT opEq     = 4'h7;
    localparam opcodeT opGt     = 4'h8;
    localparam opcodeT opAndNot = 4'h9;
    localparam opcodeT opXor    = 4'ha;
    localparam opcodeT opSub    = 4'hb;
    localparam opcodeT opXnor   = 4'hc;
    localparam opcodeT opShr    = 4'hd;
    localparam opcodeT opNe     = 4'he;

    localparam regIndexT zeroIndex = 4'h0; // Always reads zero
    localparam regIndexT pcIndex   = 4'hf; // Reads next instruction address

    // One-hot instruction phases
    localparam phaseT phaseFetch     = 4'b0001;
    localparam phaseT phaseExecute   = 4'b0010;
    localparam phaseT phaseCommit    = 4'b0100;
    localparam phaseT phaseWriteback = 4'b1000;

    localparam wordT defaultResetVector = 32'h0000_1000;

endpackage

`default_nettype wire

// File: tb/tenyrCoreTb.sv
`default_nettype none
`timescale 1ns/1ps

module tenyrCoreTb;

    import tenyrPkg::*;

    localparam wordT resetVector = 32'h0000_0400;
    localparam int   resetCycles = 10;
    localparam int   progDepth   = 128;
    localparam int   dataDepth   = 256;
    localparam int   maxStores   = 64;
    localparam int   maxSteps    = 400;

    logic clk;
    logic reset_n;
    logic enable;
    logic haltReq;
    logic dataWe;
    logic halted;
    wordT instrAddr;
    wordT instrData;
    wordT dataAddr;
    wordT dataOut;
    wordT dataIn;
    wordT progOffset;

    wordT progMem [0:progDepth-1];
    wordT dataMem [0:dataDepth-1];
    wordT dataImage [0:dataDepth-1];  // Start contents for every run
    wordT modelMem [0:dataDepth-1];
    wordT modelRegs [0:15];
    wordT expAddr [0:maxStores-1];
    wordT expData [0:maxStores-1];
    wordT expHaltPc;
    int   progLen;
    int   expCount;
    int   expSteps;
    int   obsCount;
    int   errors;
    bit   timedOut;

    // Both memories answer in the same cycle
    assign progOffset = instrAddr - resetVector;
    assign instrData  = (progOffset < progLen) ? progMem[progOffset] : '1;
    assign dataIn     = dataMem[dataAddr[7:0]];

    tenyrCore #(
        .resetVector (resetVector)
    ) u_tenyrCore (
        .clk       (clk),
        .reset_n   (reset_n),
        .enable    (enable),
        .instrAddr (instrAddr),
        .instrData (instrData),
        .dataAddr  (dataAddr),
        .dataWe    (dataWe),
        .dataOut   (dataOut),
        .dataIn    (dataIn),
        .haltReq   (haltReq),
        .halted    (halted)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    function automatic wordT encodeInstr(input bit swap, input bit store, input bit deref,
            input regIndexT z, input regIndexT x, input regIndexT y, input opcodeT op,
            input int imm);
        return {1'b0, swap, store, deref, z, x, y, op, imm[11:0]};
    endfunction

    task automatic emit(input wordT word);
        progMem[progLen] = word;
        progLen++;
    endtask

    function automatic wordT aluRef(input opcodeT op, input wordT a, input wordT b);
        wordT result;
        case (op)
            opOr:     result = a | b;
            opAnd:    result = a & b;
            opAdd:    result = a + b;
            opMul:    result = a * b;
            opShl:    result = a << b;
            opLt:     result = ($signed(a) < $signed(b)) ? '1 : '0;
            opEq:     result = (a == b) ? '1 : '0;
            opGt:     result = ($signed(a) > $signed(b)) ? '1 : '0;
            opAndNot: result = a & ~b;
            opXor:    result = a ^ b;
            opSub:    result = a - b;
            opXnor:   result = ~(a ^ b);
            opShr:    result = a >> b;
            opNe:     result = (a != b) ? '1 : '0;
            default:  result = '0;  // Reserved codes
        endcase
        return result;
    endfunction

    function automatic wordT readReg(input regIndexT idx, input wordT pc);
        return (idx == zeroIndex) ? '0 : (idx == pcIndex) ? pc + 1 : modelRegs[idx];
    endfunction

    // Instruction-set model of the expected stores and halt address
    function automatic void modelProgram(input int haltAfter);
        wordT pc;
        wordT ins;
        wordT imm;
        wordT zv;
        wordT result;
        wordT value;
        int   i;
        bit   done;
        pc = resetVector;
        expCount = 0;
        expSteps = 0;
        done = 1'b0;
        for (i = 0; i < 16; i++) modelRegs[i] = '0;
        for (i = 0; i < dataDepth; i++) modelMem[i] = dataImage[i];
        while (!done && expSteps < maxSteps) begin
            ins = (pc - resetVector < progLen) ? progMem[pc - resetVector] : '1;
            if (ins == '1) begin
                done = 1'b1;  // PC stays on the illegal word
            end else begin
                imm = {{20{ins[11]}}, ins[11:0]};
                zv  = readReg(ins[27:24], pc);
                if (ins[30]) begin
                    result = aluRef(ins[15:12], readReg(ins[23:20], pc), imm)
                        + readReg(ins[19:16], pc);
                end else begin
                    result = aluRef(ins[15:12], readReg(ins[23:20], pc),
                        readReg(ins[19:16], pc)) + imm;
                end
                pc = pc + 1;
                if (ins[29]) begin
                    expAddr[expCount] = ins[28] ? result : zv;
                    expData[expCount] = ins[28] ? zv : result;
                    modelMem[expAddr[expCount][7:0]] = expData[expCount];
                    expCount++;
                end else begin
                    value = ins[28] ? modelMem[result[7:0]] : result;
                    if (ins[27:24] == pcIndex) pc = value;
                    else if (ins[27:24] != zeroIndex) modelRegs[ins[27:24]] = value;
                end
                expSteps++;
                if (haltAfter > 0 && expCount == haltAfter) done = 1'b1;
            end
        end
        expHaltPc = pc;
    endfunction

    task automatic buildProgram();
        int op;
        int storeAddr;
        bit isShift;
        progLen = 0;
        storeAddr = 'h80;
        emit(encodeInstr(0, 0, 1, 4'd1, zeroIndex, zeroIndex, opOr, 'h01));  // r1 from memory
        emit(encodeInstr(0, 0, 1, 4'd2, zeroIndex, zeroIndex, opOr, 'h02));
        emit(encodeInstr(0, 0, 0, 4'd3, zeroIndex, zeroIndex, opOr, $urandom_range(31, 0)));
        for (op = 0; op < 16; op++) begin
            isShift = (op == opShl) || (op == opShr);  // Keep shift counts small
            emit(encodeInstr(0, 0, 0, 4'd4, 4'd1, isShift ? 4'd3 : 4'd2, op[3:0],
                $urandom_range(4095, 0)));
            emit(encodeInstr(0, 1, 1, 4'd4, zeroIndex, zeroIndex, opOr, storeAddr));
            emit(encodeInstr(1, 0, 0, 4'd4, 4'd1, 4'd2, op[3:0],
                isShift ? $urandom_range(31, 0) : $urandom_range(4095, 0)));
            emit(encodeInstr(0, 1, 1, 4'd4, zeroIndex, zeroIndex, opOr, storeAddr + 1));
            storeAddr = storeAddr + 2;
        end
        emit(encodeInstr(0, 0, 0, zeroIndex, 4'd1, zeroIndex, opOr, 5));  // Lost write
        emit(encodeInstr(0, 1, 1, zeroIndex, zeroIndex, zeroIndex, opOr, 'hA0));
        emit(encodeInstr(0, 1, 1, pcIndex, zeroIndex, zeroIndex, opOr, 'hA1));
        emit(encodeInstr(0, 0, 0, 4'd6, pcIndex, zeroIndex, opAdd, 0));
        emit(encodeInstr(0, 1, 1, 4'd6, zeroIndex, zeroIndex, opOr, 'hA2));
        emit(encodeInstr(0, 0, 1, 4'd7, zeroIndex, zeroIndex, opOr, 'h10));  // Load
        emit(encodeInstr(0, 0, 0, 4'd9, zeroIndex, zeroIndex, opOr, 'hC0));
        emit(encodeInstr(0, 1, 0, 4'd9, 4'd7, zeroIndex, opOr, $urandom_range(4095, 0)));
        emit(encodeInstr(0, 0, 0, pcIndex, pcIndex, zeroIndex, opOr, 1));  // Jump over next
        emit(encodeInstr(0, 1, 1, 4'd1, zeroIndex, zeroIndex, opOr, 'hA3));
        emit(encodeInstr(0, 0, 0, 4'd10, 4'd1, 4'd1, opEq, 0));
        emit(encodeInstr(1, 0, 0, pcIndex, 4'd10, pcIndex, opAnd, 1));  // Taken
        emit(encodeInstr(0, 1, 1, 4'd2, zeroIndex, zeroIndex, opOr, 'hA4));
        emit(encodeInstr(0, 0, 0, 4'd11, 4'd1, 4'd1, opNe, 0));
        emit(encodeInstr(1, 0, 0, pcIndex, 4'd11, pcIndex, opAnd, 1));  // Not taken
        emit(encodeInstr(0, 1, 1, 4'd2, zeroIndex, zeroIndex, opOr, 'hA5));
        emit('1);
        emit(encodeInstr(0, 1, 1, 4'd1, zeroIndex, zeroIndex, opOr, 'hA6));  // Never reached
    endtask

    // Store checker and data memory write port
    always @(posedge clk) begin
        if (reset_n && dataWe) begin
            assert (obsCount < expCount) else begin
                errors++;
                $display("Unexpected store to %h after the last expected store", dataAddr);
            end
            if (obsCount < expCount) begin
                assert (dataAddr == expAddr[obsCount]) else begin
                    errors++;
                    $display("FAILED at %0t: dataAddr = %h, expected %h",
                        $time, dataAddr, expAddr[obsCount]);
                end
                assert (dataOut == expData[obsCount]) else begin
                    errors++;
                    $display("FAILED at %0t: dataOut = %h, expected %h",
                        $time, dataOut, expData[obsCount]);
                end
            end
            dataMem[dataAddr[7:0]] <= dataOut;
            obsCount++;
        end
    end

    task automatic runProgram(input bit freeze, input int haltAfter);
        int limit;
        int cycles;
        int holdLeft;
        int i;
        modelProgram(haltAfter);
        limit = 4 * (expSteps + 1) + resetCycles + 50;
        @(negedge clk);
        reset_n = 1'b0;
        enable  = 1'b0;
        haltReq = 1'b0;
        for (i = 0; i < dataDepth; i++) dataMem[i] = dataImage[i];
        obsCount = 0;
        repeat (resetCycles) @(negedge clk);
        reset_n  = 1'b1;
        enable   = 1'b1;
        cycles   = 0;
        holdLeft = 0;
        while (!halted && !timedOut) begin
            @(negedge clk);
            if (haltAfter > 0 && obsCount >= haltAfter) haltReq = 1'b1;
            if (freeze && holdLeft == 0) begin
                enable   = !enable;
                holdLeft = enable ? $urandom_range(12, 1) : $urandom_range(5, 1);
            end else if (freeze) begin
                holdLeft--;
            end
            if (enable) cycles++;  // Frozen cycles do not count
            if (cycles > limit) begin
                timedOut = 1'b1;
                errors++;
                $display("Timeout: core not halted within %0d active cycles", limit);
            end
        end
        if (!timedOut) begin
            assert (instrAddr == expHaltPc) else begin
                errors++;
                $display("FAILED at %0t: instrAddr = %h, expected %h",
                    $time, instrAddr, expHaltPc);
            end
            enable = 1'b1;
            repeat (8) @(negedge clk);  // Look for stray stores after the halt
            assert (obsCount == expCount) else begin
                errors++;
                $display("Run ended with %0d stores where %0d were expected", obsCount, expCount);
            end
            assert (halted) else begin
                errors++;
                $display("The halted flag dropped before reset");
            end
        end
        haltReq = 1'b0;
    endtask

    initial begin
        int   i;
        int   haltPoint;
        wordT seedValue;
        seedValue = 32'h134df684;
        void'($urandom(seedValue));
        reset_n  = 1'b0;
        enable   = 1'b0;
        haltReq  = 1'b0;
        errors   = 0;
        obsCount = 0;
        expCount = 0;
        timedOut = 1'b0;
        for (i = 0; i < dataDepth; i++) dataImage[i] = $urandom;
        buildProgram();
        haltPoint = $urandom_range(20, 5);
        runProgram(1'b0, 0);
        if (!timedOut) runProgram(1'b1, 0);  // Random enable stretches
        if (!timedOut) runProgram(1'b0, haltPoint);
        $display("Store checks finished with %0d error(s)", errors);
        if (errors == 0 && !timedOut) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: tenyrCore.f
design/tenyrPkg.sv
design/instrDecoder.sv
design/regFile.sv
design/execUnit.sv
design/phaseSequencer.sv
design/programCounter.sv
design/tenyrCore.sv
tb/tenyrCoreTb.sv
